// File: cop_mem_sys.f
+incdir+include
source/cop_isa_pkg.sv
source/cop_bus_pkg.sv
source/cop_apb_regs.sv
source/cop_decode.sv
source/cop_mem.sv
source/cop_cpr_file.sv
source/cop_top.sv
dv/cop_asserts.sv
dv/tb_cop.sv

// File: dv/cop_asserts.sv
// Bound checks on the memory request handshake and the completion pulse of the memory engine
module cop_asserts import cop_bus_pkg::*; (
    input logic     g_clk,
    input logic     g_resetn,
    input mem_req_t mem_req,
    input mem_rsp_t mem_rsp,
    input logic     idone,
    input logic     addr_err
);

    int unsigned fail_cnt = 0;  // Read by the testbench at the end

    // Request must not move while the memory stalls
    hold_on_stall: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $past(mem_req.cen) && mem_rsp.stall |-> mem_req == $past(mem_req))
        else begin
            fail_cnt++;
            $error("memory request changed while the memory stalled");
        end

    idone_pulse: assert property (@(posedge g_clk) disable iff (!g_resetn)
        idone |=> !idone)
        else begin
            fail_cnt++;
            $error("idone stayed high for more than one cycle");
        end

    // Misaligned or illegal operations never reach the bus, not even a cycle earlier
    no_req_on_addr_err: assert property (@(posedge g_clk) disable iff (!g_resetn)
        addr_err |-> !mem_req.cen && !$past(mem_req.cen))
        else begin
            fail_cnt++;
            $error("memory request raised for an instruction with addr_err");
        end

endmodule

bind cop_mem cop_asserts u_asserts (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .idone    (idone),
    .addr_err (addr_err)
);

// File: dv/tb_cop.sv
// Testbench for the coprocessor load/store unit with random instructions and a reference model
`include "cop_apb_map.svh"

module tb_cop import cop_isa_pkg::*; import cop_bus_pkg::*; ();

    localparam int NUM_RAND   = 60;
    localparam int NUM_POKE   = 4;   // Gathers hit by a second INSTR write
    localparam int NUM_INSTR  = NUM_RAND + NUM_POKE;
    localparam int MAX_CYCLES = 200 * NUM_INSTR;

    logic        g_clk;
    logic        g_resetn;
    apb_req_t    apb;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    logic [31:0] mem [256];          // Memory model, addressed by addr[9:2]
    logic [31:0] ref_mem [256];
    logic [31:0] ref_cpr [NUM_CPR];
    integer      seed = 32'hca1;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          acc_count = 0;      // Accesses answered by the memory model
    logic        acc_open = 1'b0;
    int          stall_left = 0;
    mem_req_t    acc_req;

    cop_top i_dut (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .apb      (apb),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    function automatic int unsigned urand(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic int elem_size(input logic [4:0] sc);
        if (sc inside {SC_LD_W, SC_ST_W}) return 4;
        if (sc inside {SC_LH, SC_ST_H, SC_GATHER_H, SC_SCATTER_H}) return 2;
        return 1;
    endfunction

    function automatic bit is_sg(input logic [4:0] sc);
        return sc inside {SC_GATHER_B, SC_GATHER_H, SC_SCATTER_B, SC_SCATTER_H};
    endfunction

    // Puts size bytes of val into word starting at byte off
    function automatic logic [31:0] merge(input logic [31:0] word, input logic [31:0] val,
                                          input int off, input int size);
        logic [31:0] res;
        res = word;
        for (int b = 0; b < size; b++) begin
            res[8*(off+b) +: 8] = val[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%08h exp 0x%08h", name, got, exp);
        end
    endtask

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge g_clk);
        apb <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge g_clk);
        apb.penable <= 1'b1;
        @(negedge g_clk);            // Mid access phase
        rdata = prdata;
        err   = pslverr;
        check("pready", pready, 1'b1);
        @(posedge g_clk);
        apb <= '0;
    endtask

    // Memory: 0 to 2 stall cycles per access, top 16 words answer with error
    always @(posedge g_clk) begin
        logic [7:0] idx;
        logic       err;
        if (!(acc_open && mem_rsp.stall)) begin
            acc_open = g_resetn && mem_req.cen === 1'b1;
            acc_req  = mem_req;
            if (acc_open) stall_left = urand(3);
        end
        if (!acc_open) begin
            mem_rsp <= '0;
        end else if (stall_left > 0) begin
            stall_left--;
            mem_rsp <= '{rdata: 32'h0, stall: 1'b1, error: 1'b0};
        end else begin
            idx = acc_req.addr[9:2];
            err = idx >= 8'd240;
            if (!err && acc_req.wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (acc_req.ben[b]) mem[idx][8*b +: 8] = acc_req.wdata[8*b +: 8];
                end
            end
            acc_count++;
            mem_rsp <= '{rdata: mem[idx], stall: 1'b0, error: err};
        end
    end

    // Applies one instruction to ref_cpr and ref_mem
    task automatic model_instr(input logic [4:0] sc, input logic [3:0] crd,
                               input logic [3:0] crs2, input logic [3:0] crs3,
                               input logic [31:0] imm, input logic [1:0] wb,
                               input logic [31:0] rs1, output logic aerr,
                               output logic berr, output int nacc);
        logic [31:0] addrs [4];
        logic [31:0] rs2v;
        logic [31:0] rs3v;
        logic [31:0] val;
        logic [7:0]  idx;
        int          size;
        int          n;
        int          lane;
        bit          sg;
        bit          load;
        rs2v = ref_cpr[crs2];
        rs3v = ref_cpr[crs3];
        sg   = is_sg(sc);
        size = elem_size(sc);
        n    = sg ? 4 / size : 1;
        load = sc inside {SC_LD_W, SC_LH, SC_LB, SC_GATHER_B, SC_GATHER_H};
        aerr = 1'b0;
        berr = 1'b0;
        nacc = 0;
        for (int e = 0; e < n; e++) begin
            addrs[e] = rs1 + (sg ? (rs2v >> (8 * size * e)) & (size == 1 ? 32'hff : 32'hffff)
                                 : imm);
            if ((addrs[e] & (size - 1)) != 0) aerr = 1'b1;
        end
        if (aerr) return;            // No access at all
        for (int e = 0; e < n; e++) begin
            idx  = addrs[e][9:2];
            lane = sg ? size * e : (size == 2 ? 2 * wb[1] : (size == 1 ? wb : 0));
            nacc++;
            if (idx >= 8'd240) begin
                berr = 1'b1;
                return;
            end
            if (load) begin
                val = ref_mem[idx] >> (8 * addrs[e][1:0]);
                ref_cpr[crd] = merge(ref_cpr[crd], val, lane, size);
            end else begin
                val = (sg ? rs3v : rs2v) >> (8 * lane);
                ref_mem[idx] = merge(ref_mem[idx], val, addrs[e][1:0], size);
            end
        end
    endtask

    // Mode 0 misaligned, 1 bus error region, otherwise a good address
    task automatic run_instr(input logic [4:0] sc, input int mode, input bit poke);
        cop_instr_t  iw;
        logic [31:0] vals [NUM_CPR];
        logic [31:0] rs1;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] rdata;
        logic [31:0] exp_st;
        logic [3:0]  crd;
        logic [3:0]  crs2;
        logic [3:0]  crs3;
        logic [1:0]  wb;
        logic        err;
        logic        exp_aerr;
        logic        exp_berr;
        int          exp_acc;
        int          acc_start;
        int          size;
        int          k;
        size = elem_size(sc);
        crd  = urand(16);
        crs2 = urand(16);
        crs3 = urand(16);
        if (sc inside {SC_GATHER_B, SC_GATHER_H} && crd == crs2) crd = crs2 + 4'd1;
        wb   = urand(4);
        imm  = int'(urand(256)) - 128;
        for (int i = 0; i < NUM_CPR; i++) vals[i] = $random(seed);
        if (!is_sg(sc)) begin
            a = (mode == 1) ? 32'h3c0 + urand(32'h40) : 32'h100 + urand(32'h2c0);
            a = a & ~(size - 1);
            if (mode == 0 && size > 1) a = a ^ (urand(size - 1) + 1);
            rs1 = a - imm;
        end else if (mode == 1) begin
            rs1 = 32'h300;
            k   = urand(4 / size);
            vals[crs2] = $random(seed) & (size == 1 ? 32'h7f7f7f7f : 32'h007e007e);
            if (size == 1) vals[crs2][8*k +: 8] = 8'hc0 | 8'(urand(64));
            else vals[crs2][16*k +: 16] = 16'h00c0 | 16'(urand(32) << 1);
        end else begin
            rs1 = size == 1 ? urand(32'h140) : urand(32'h1c0) & ~32'h1;
            vals[crs2] = $random(seed) & (size == 1 ? 32'hffffffff : 32'h01fe01fe);
            k   = 16 * urand(2);
            if (mode == 0 && size == 2) vals[crs2][k] = 1'b1;  // Odd offset
        end

        iw          = '0;
        iw.iclass   = ICLASS_LOADSTORE;
        iw.subclass = sc;
        iw.crd      = crd;
        iw.crs2     = crs2;
        if (is_sg(sc)) begin
            iw.ext.sg.crs3 = crs3;
        end else begin
            iw.ext.ls.imm  = imm[13:0];
            iw.ext.ls.wb_h = wb[1];
            iw.ext.ls.wb_b = wb[0];
        end

        for (int i = 0; i < NUM_CPR; i++) begin
            apb_access(1'b1, `COP_REG_CPR_LO + 8'(4 * i), vals[i], rdata, err);
            check("pslverr", err, 1'b0);
            ref_cpr[i] = vals[i];
        end
        apb_access(1'b1, `COP_REG_RS1, rs1, rdata, err);
        check("pslverr", err, 1'b0);
        acc_start = acc_count;
        apb_access(1'b1, `COP_REG_INSTR, iw, rdata, err);
        check("pslverr", err, 1'b0);
        if (poke) begin
            apb_access(1'b1, `COP_REG_INSTR, $random(seed), rdata, err);
            check("pslverr", err, 1'b1);  // Refused while busy
        end
        model_instr(sc, crd, crs2, crs3, imm, wb, rs1, exp_aerr, exp_berr, exp_acc);

        rdata = '0;
        while (rdata[`COP_ST_DONE] !== 1'b1) begin
            apb_access(1'b0, `COP_REG_STATUS, 32'h0, rdata, err);
        end
        exp_st = '0;
        exp_st[`COP_ST_DONE]     = 1'b1;
        exp_st[`COP_ST_ADDR_ERR] = exp_aerr;
        exp_st[`COP_ST_BUS_ERR]  = exp_berr;
        check("status", rdata, exp_st);
        check("accesses", acc_count - acc_start, exp_acc);
        for (int i = 0; i < NUM_CPR; i++) begin
            apb_access(1'b0, `COP_REG_CPR_LO + 8'(4 * i), 32'h0, rdata, err);
            check($sformatf("cpr%0d", i), rdata, ref_cpr[i]);
        end
        for (int i = 0; i < 256; i++) check($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    endtask

    always @(posedge g_clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks %0d, errors %0d", checks, errors + 1);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [4:0] sc_tab [10];
        g_resetn = 1'b0;
        apb      = '0;
        mem_rsp  = '0;
        sc_tab   = '{SC_LD_W, SC_LH, SC_LB, SC_ST_W, SC_ST_H, SC_ST_B,
                     SC_GATHER_B, SC_GATHER_H, SC_SCATTER_B, SC_SCATTER_H};
        for (int i = 0; i < 256; i++) begin
            mem[i]     = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i * 7)};
            ref_mem[i] = mem[i];
        end
        repeat (3) @(posedge g_clk);
        g_resetn <= 1'b1;
        for (int t = 0; t < NUM_RAND; t++) run_instr(sc_tab[urand(10)], urand(8), 1'b0);
        for (int t = 0; t < NUM_POKE; t++) run_instr(SC_GATHER_B, 2, 1'b1);
        errors += i_dut.u_mem.u_asserts.fail_cnt;
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: include/cop_apb_map.svh
// APB register offsets and STATUS bit positions of the coprocessor load/store unit
`ifndef COP_APB_MAP_SVH
`define COP_APB_MAP_SVH

// Register offsets
`define COP_REG_INSTR    8'h00  // Instruction word, write starts execution
`define COP_REG_RS1      8'h04  // General register operand
`define COP_REG_STATUS   8'h08  // Read clears done and error flags

// One word per CPR
`define COP_REG_CPR_LO   8'h40
`define COP_REG_CPR_HI   8'h7C

// STATUS bit positions
`define COP_ST_BUSY      0
`define COP_ST_DONE      1
`define COP_ST_ADDR_ERR  2
`define COP_ST_BUS_ERR   3

`endif

// File: source/cop_apb_regs.sv
// APB slave holding the instruction, RS1 and STATUS registers and the CPR window
`include "cop_apb_map.svh"

module cop_apb_regs import cop_isa_pkg::*; import cop_bus_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  apb_req_t    apb,
    input  logic        idone,
    input  logic        addr_err,
    input  logic        bus_err,
    input  logic [31:0] cpr_rdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output cop_instr_t  instr,
    output logic [31:0] rs1,
    output logic        ivalid,
    output logic [3:0]  cpr_ridx,
    output cpr_wr_t     host_wr
);

    logic busy;
    logic done;
    logic aerr_q;
    logic berr_q;
    logic acc_wr;
    logic acc_rd;
    logic hit_instr;
    logic hit_rs1;
    logic hit_status;
    logic hit_win;

    assign acc_wr     = apb.psel && apb.penable && apb.pwrite;
    assign acc_rd     = apb.psel && apb.penable && !apb.pwrite;
    assign hit_instr  = apb.paddr == `COP_REG_INSTR;
    assign hit_rs1    = apb.paddr == `COP_REG_RS1;
    assign hit_status = apb.paddr == `COP_REG_STATUS;
    assign hit_win    = apb.paddr >= `COP_REG_CPR_LO && apb.paddr <= `COP_REG_CPR_HI;

    assign pready  = 1'b1;     // No wait states
    assign pslverr = acc_wr && busy && (hit_instr || hit_rs1 || hit_win);
    assign ivalid  = busy;

    // CPR window reads go through the third read port
    assign cpr_ridx = apb.paddr[5:2];
    assign host_wr  = '{en: acc_wr && hit_win && !busy, idx: apb.paddr[5:2],
                        ben: 4'hf, data: apb.pwdata};

    always_comb begin
        prdata = '0;
        if (hit_instr) begin
            prdata = instr;
        end else if (hit_rs1) begin
            prdata = rs1;
        end else if (hit_status) begin
            prdata[`COP_ST_BUSY]     = busy;
            prdata[`COP_ST_DONE]     = done;
            prdata[`COP_ST_ADDR_ERR] = aerr_q;
            prdata[`COP_ST_BUS_ERR]  = berr_q;
        end else if (hit_win) begin
            prdata = cpr_rdata;
        end
    end

    always_ff @(posedge g_clk) begin
        if (acc_wr && !busy && hit_instr) begin
            instr <= cop_instr_t'(apb.pwdata);
        end
        if (acc_wr && !busy && hit_rs1) begin
            rs1 <= apb.pwdata;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            busy   <= 1'b0;
            done   <= 1'b0;
            aerr_q <= 1'b0;
            berr_q <= 1'b0;
        end else begin
            if (acc_rd && hit_status) begin   // Read to clear
                done   <= 1'b0;
                aerr_q <= 1'b0;
                berr_q <= 1'b0;
            end
            if (idone) begin
                busy   <= 1'b0;
                done   <= 1'b1;
                aerr_q <= aerr_q || addr_err; // Sticky until read
                berr_q <= berr_q || bus_err;
            end else if (acc_wr && hit_instr && !busy) begin
                busy <= 1'b1;
            end
        end
    end

endmodule

// File: source/cop_bus_pkg.sv
// Bus and register write types shared by the coprocessor load/store unit blocks
package cop_bus_pkg;

    // Host side APB request
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Memory request, held until accepted
    typedef struct packed {
        logic        cen;
        logic        wen;
        logic [31:0] addr;          // Word aligned
        logic [31:0] wdata;
        logic [3:0]  ben;
    } mem_req_t;

    // Memory response, valid the cycle after the request
    typedef struct packed {
        logic [31:0] rdata;
        logic        stall;
        logic        error;
    } mem_rsp_t;

    // Byte lane write into the CPR file
    typedef struct packed {
        logic        en;
        logic [3:0]  idx;
        logic [3:0]  ben;
        logic [31:0] data;
    } cpr_wr_t;

endpackage

// File: source/cop_cpr_file.sv
// Sixteen 32-bit coprocessor registers with byte lane writes and three read ports
module cop_cpr_file import cop_isa_pkg::*; import cop_bus_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  cpr_wr_t     mem_wr,
    input  cpr_wr_t     host_wr,
    input  logic [3:0]  ridx_0,
    input  logic [3:0]  ridx_1,
    input  logic [3:0]  ridx_2,
    output logic [31:0] rdata_0,
    output logic [31:0] rdata_1,
    output logic [31:0] rdata_2
);

    logic [31:0] cpr [NUM_CPR];
    cpr_wr_t     wr;

    // Memory engine first, host writes only happen while idle
    assign wr = mem_wr.en ? mem_wr : host_wr;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < NUM_CPR; i++) begin
                cpr[i] <= '0;
            end
        end else if (wr.en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.ben[b]) begin
                    cpr[wr.idx][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

    assign rdata_0 = cpr[ridx_0];  // rs2
    assign rdata_1 = cpr[ridx_1];  // rs3
    assign rdata_2 = cpr[ridx_2];  // Host window

endmodule

// File: source/cop_decode.sv
// Decodes the load/store instruction word into one-hot operation flags and operands
module cop_decode import cop_isa_pkg::*; (
    input  cop_instr_t  instr,
    input  logic [31:0] rs2_val,
    input  logic [31:0] rs3_val,
    output logic [3:0]  rs2_idx,
    output logic [3:0]  rs3_idx,
    output cop_op_t     op
);

    logic is_ls;
    logic is_sg;

    assign is_ls = instr.iclass == ICLASS_LOADSTORE;

    // Scatter/gather subclasses use the crs3 view of the upper half
    assign is_sg = is_ls && (instr.subclass == SC_GATHER_B ||
                             instr.subclass == SC_GATHER_H ||
                             instr.subclass == SC_SCATTER_B ||
                             instr.subclass == SC_SCATTER_H);

    assign rs2_idx = instr.crs2;
    assign rs3_idx = is_sg ? instr.ext.sg.crs3 : 4'd0;

    always_comb begin
        op = '0;
        if (is_ls) begin
            case (instr.subclass)
                SC_LD_W:      op.lw   = 1'b1;
                SC_LH:        op.lh   = 1'b1;
                SC_LB:        op.lb   = 1'b1;
                SC_ST_W:      op.sw   = 1'b1;
                SC_ST_H:      op.sh   = 1'b1;
                SC_ST_B:      op.sb   = 1'b1;
                SC_GATHER_B:  op.ga_b = 1'b1;
                SC_GATHER_H:  op.ga_h = 1'b1;
                SC_SCATTER_B: op.sc_b = 1'b1;
                SC_SCATTER_H: op.sc_h = 1'b1;
                default:      op.lw   = 1'b0;   // Unknown kind stays illegal
            endcase
        end

        // Immediate and lane selects only exist in the load/store view
        if (!is_sg) begin
            op.imm  = {{18{instr.ext.ls.imm[13]}}, instr.ext.ls.imm};
            op.wb_h = instr.ext.ls.wb_h;
            op.wb_b = instr.ext.ls.wb_b;
        end

        op.crd = instr.crd;
        op.rs2 = rs2_val;
        op.rs3 = rs3_val;
    end

endmodule

// File: source/cop_isa_pkg.sv
// Instruction encodings and decoded operation types of the coprocessor load/store unit
package cop_isa_pkg;

    localparam int NUM_CPR = 16;

    localparam logic [2:0] ICLASS_LOADSTORE = 3'b001;

    // Load/store subclasses
    localparam logic [4:0] SC_LD_W      = 5'd0;
    localparam logic [4:0] SC_LH        = 5'd1;
    localparam logic [4:0] SC_LB        = 5'd2;
    localparam logic [4:0] SC_ST_W      = 5'd4;
    localparam logic [4:0] SC_ST_H      = 5'd5;
    localparam logic [4:0] SC_ST_B      = 5'd6;
    localparam logic [4:0] SC_GATHER_B  = 5'd8;
    localparam logic [4:0] SC_GATHER_H  = 5'd9;
    localparam logic [4:0] SC_SCATTER_B = 5'd10;
    localparam logic [4:0] SC_SCATTER_H = 5'd11;

    // Upper half of the instruction as seen by single loads and stores
    typedef struct packed {
        logic signed [13:0] imm;
        logic               wb_h;   // Halfword lane select
        logic               wb_b;   // Byte lane select
    } cop_ls_fields_t;

    // Same bits as seen by scatter and gather
    typedef struct packed {
        logic [11:0] rsvd;
        logic [3:0]  crs3;          // Data source for scatter
    } cop_sg_fields_t;

    typedef union packed {
        cop_ls_fields_t ls;
        cop_sg_fields_t sg;
    } cop_ext_u;

    typedef struct packed {
        cop_ext_u   ext;            // Bits 31:16
        logic [3:0] crs2;
        logic [3:0] crd;
        logic [4:0] subclass;
        logic [2:0] iclass;         // Bits 2:0
    } cop_instr_t;

    typedef struct packed {
        logic        lw;
        logic        lh;
        logic        lb;
        logic        sw;
        logic        sh;
        logic        sb;
        logic        ga_b;
        logic        ga_h;
        logic        sc_b;
        logic        sc_h;
        logic        wb_h;
        logic        wb_b;
        logic [31:0] imm;           // Sign extended
        logic [3:0]  crd;
        logic [31:0] rs2;
        logic [31:0] rs3;
    } cop_op_t;

endpackage

// File: source/cop_mem.sv
// Memory engine with address generation, byte lanes and scatter/gather sequencing
module cop_mem import cop_isa_pkg::*; import cop_bus_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        ivalid,
    input  cop_op_t     op,
    input  logic [31:0] rs1,
    input  mem_rsp_t    mem_rsp,
    output logic        idone,
    output logic        addr_err,
    output logic        bus_err,
    output mem_req_t    mem_req,
    output cpr_wr_t     cpr_wr
);

    logic        sg_b;
    logic        sg_h;
    logic        is_half;
    logic        is_byte;
    logic        is_load;
    logic        is_store;
    logic        legal;
    logic [1:0]  w_lsbs;
    logic        w_misal;
    logic        h_misal;
    logic        sgh_misal;
    logic        p_cen;           // Request was live last cycle
    logic [1:0]  p_lsbs;          // Byte offset of that request
    logic [1:0]  elem_q;          // Element awaiting its response
    logic [1:0]  req_elem;        // Element being requested now
    logic        last_elem;
    logic        rsp_end;
    logic        txn_good;
    logic [31:0] offset;
    logic [31:0] addr;
    logic [15:0] st_half;
    logic [7:0]  st_byte;
    logic [15:0] ld_half;
    logic [7:0]  ld_byte;
    logic        wb_hi;
    logic [1:0]  wb_lane;

    assign sg_b     = op.ga_b || op.sc_b;
    assign sg_h     = op.ga_h || op.sc_h;
    assign is_half  = op.lh || op.sh || sg_h;
    assign is_byte  = op.lb || op.sb || sg_b;
    assign is_load  = op.lw || op.lh || op.lb || op.ga_b || op.ga_h;
    assign is_store = op.sw || op.sh || op.sb || op.sc_b || op.sc_h;
    assign legal    = is_load || is_store;

    // Alignment from operands, so it never waits on the adder
    assign w_lsbs    = rs1[1:0] + op.imm[1:0];
    assign w_misal   = (op.lw || op.sw) && w_lsbs != 2'b00;
    assign h_misal   = (op.lh || op.sh) && (rs1[0] ^ op.imm[0]);
    assign sgh_misal = sg_h && ((rs1[0] ^ op.rs2[0]) || (rs1[0] ^ op.rs2[16]));

    assign addr_err = ivalid && (!legal || w_misal || h_misal || sgh_misal);

    // An access ends once the cycle after a request sees no stall
    assign rsp_end  = p_cen && !mem_rsp.stall;
    assign txn_good = rsp_end && !mem_rsp.error;
    assign bus_err  = ivalid && rsp_end && mem_rsp.error;

    assign last_elem = sg_b ? elem_q == 2'd3 :
                       sg_h ? elem_q == 2'd1 : 1'b1;

    assign idone = ivalid && (addr_err || bus_err || (txn_good && last_elem));

    // Next element goes out in the same cycle the previous one returns
    assign req_elem = txn_good ? elem_q + 2'd1 : elem_q;

    always_comb begin
        if (sg_b) begin
            offset = {24'd0, op.rs2[8*req_elem +: 8]};
        end else if (sg_h) begin
            offset = {16'd0, op.rs2[16*req_elem[0] +: 16]};
        end else begin
            offset = op.imm;
        end
    end

    assign addr = rs1 + offset;

    // Store data, from rs2 for single stores and rs3 for scatter
    assign st_half = op.sh ? (op.wb_h ? op.rs2[31:16] : op.rs2[15:0]) :
                             op.rs3[16*req_elem[0] +: 16];
    assign st_byte = op.sb ? op.rs2[8*{op.wb_h, op.wb_b} +: 8] :
                             op.rs3[8*req_elem +: 8];

    always_comb begin
        mem_req.cen  = ivalid && !idone;
        mem_req.wen  = is_store;
        mem_req.addr = {addr[31:2], 2'b00};
        if (is_half) begin
            mem_req.ben   = addr[1] ? 4'b1100 : 4'b0011;
            mem_req.wdata = {16'd0, st_half} << (addr[1] ? 16 : 0);
        end else if (is_byte) begin
            mem_req.ben   = 4'b0001 << addr[1:0];
            mem_req.wdata = {24'd0, st_byte} << {addr[1:0], 3'b000};
        end else begin
            mem_req.ben   = 4'hf;
            mem_req.wdata = op.rs2;
        end
    end

    // Load data picked from the lane of the request that just returned
    assign ld_half = p_lsbs[1] ? mem_rsp.rdata[31:16] : mem_rsp.rdata[15:0];
    assign ld_byte = mem_rsp.rdata[8*p_lsbs +: 8];

    // Destination lane in crd
    assign wb_hi   = op.lh ? op.wb_h : elem_q[0];
    assign wb_lane = op.lb ? {op.wb_h, op.wb_b} : elem_q;

    always_comb begin
        cpr_wr.en  = ivalid && txn_good && is_load;
        cpr_wr.idx = op.crd;
        if (is_half) begin
            cpr_wr.ben  = wb_hi ? 4'b1100 : 4'b0011;
            cpr_wr.data = {2{ld_half}};
        end else if (is_byte) begin
            cpr_wr.ben  = 4'b0001 << wb_lane;
            cpr_wr.data = {4{ld_byte}};
        end else begin
            cpr_wr.ben  = 4'hf;
            cpr_wr.data = mem_rsp.rdata;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            p_cen  <= 1'b0;
            elem_q <= 2'd0;
        end else begin
            p_cen <= mem_req.cen;
            if (idone) begin
                elem_q <= 2'd0;                 // Ready for next instruction
            end else if (txn_good) begin
                elem_q <= elem_q + 2'd1;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        p_lsbs <= addr[1:0];
    end

endmodule

// File: source/cop_top.sv
// Top level of the coprocessor load/store unit with APB host port and memory bus
module cop_top import cop_isa_pkg::*; import cop_bus_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  apb_req_t    apb,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp
);

    cop_instr_t  instr;
    cop_op_t     op;
    logic [31:0] rs1;
    logic        ivalid;
    logic        idone;
    logic        addr_err;
    logic        bus_err;
    logic [3:0]  host_ridx;
    logic [31:0] host_rdata;
    cpr_wr_t     host_wr;
    cpr_wr_t     mem_wr;
    logic [3:0]  rs2_idx;
    logic [3:0]  rs3_idx;
    logic [31:0] rs2_val;
    logic [31:0] rs3_val;

    cop_apb_regs u_apb_regs (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .apb       (apb),
        .idone     (idone),
        .addr_err  (addr_err),
        .bus_err   (bus_err),
        .cpr_rdata (host_rdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .instr     (instr),
        .rs1       (rs1),
        .ivalid    (ivalid),
        .cpr_ridx  (host_ridx),
        .host_wr   (host_wr)
    );

    cop_decode u_decode (
        .instr   (instr),
        .rs2_val (rs2_val),
        .rs3_val (rs3_val),
        .rs2_idx (rs2_idx),
        .rs3_idx (rs3_idx),
        .op      (op)
    );

    cop_mem u_mem (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .ivalid   (ivalid),
        .op       (op),
        .rs1      (rs1),
        .mem_rsp  (mem_rsp),
        .idone    (idone),
        .addr_err (addr_err),
        .bus_err  (bus_err),
        .mem_req  (mem_req),
        .cpr_wr   (mem_wr)
    );

    cop_cpr_file u_cpr_file (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .mem_wr   (mem_wr),
        .host_wr  (host_wr),
        .ridx_0   (rs2_idx),
        .ridx_1   (rs3_idx),
        .ridx_2   (host_ridx),
        .rdata_0  (rs2_val),
        .rdata_1  (rs3_val),
        .rdata_2  (host_rdata)
    );

endmodule
